/* verif/huff_len_input.txt */
// shape (0 balanced, 1 chain, 2 random)  leaves  expected count sum
// expected longest length (0 leaves it unchecked), all values in hex
0 100 100 8
2 064 064 0
1 028 028 f
0 000 000 0
1 011 011 f
1 010 010 f
0 002 002 1
2 100 100 0
1 100 100 f
2 00a 00a 0
0 040 040 6
2 0c8 0c8 0
1 003 003 2
0 005 005 3

/* compile.f */
+incdir+verilog
verilog/huff_len_pkg.sv
verilog/tree_tracer.sv
verilog/bl_count_array.sv
verilog/length_limiter.sv
verilog/huff_len_top.sv
verif/huff_len_assert.sv
verif/tb_huff_len.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --assert -j 0 -Wno-fatal
TOP      := tb_huff_len
FILELIST := compile.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(wildcard verilog/*.sv verilog/*.svh verif/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q -F '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verif/tb_huff_len.sv */
`timescale 1ns/100ps
`default_nettype none
`include "huff_len_macros.svh"

module tb_huff_len;

	localparam int          NODES     = 1 << `HL_NODE_W;
	localparam int          MAX_TESTS = 16;
	localparam logic [11:0] END_MARK  = 12'hfff;

	logic                  clk = 1'b0;
	logic                  rstN = 1'b1;
	logic                  start;
	logic                  done;
	logic                  tree_rd;
	logic [`HL_NODE_W-1:0] tree_addr;
	logic [`HL_NODE_W-1:0] tree_parent = '0;
	logic [`HL_LEN_W-1:0]  rd_addr;
	logic [`HL_CNT_W-1:0]  rd_count;

	// tree RAM model, each entry holds the parent of its node
	logic [`HL_NODE_W-1:0] tree_mem [0:NODES-1];
	logic [`HL_NODE_W-1:0] ram_q = '0;
	// four words per test: shape, leaves, count sum, longest length
	logic [11:0]           test_words [0:4*MAX_TESTS-1];
	int                    model_cnt [0:`HL_MAX_BITS];
	integer                seed = 32'h481c3731;
	int                    err_cnt = 0;
	int                    check_cnt = 0;
	int                    tests_failed = 0;
	int                    cycle_cnt = 0;
	int                    timeout_limit = 0;

	huff_len_top UUT
	(
		.clk         (clk),
		.rstN        (rstN),
		.start       (start),
		.done        (done),
		.tree_rd     (tree_rd),
		.tree_addr   (tree_addr),
		.tree_parent (tree_parent),
		.rd_addr     (rd_addr),
		.rd_count    (rd_count)
	);

	always #2 clk = ~clk;

	// read taken at the rising edge, answer driven at the falling edge
	always @(posedge clk)
	begin
		if (tree_rd)
			ram_q <= tree_mem[tree_addr];
	end

	always @(negedge clk)
	begin
		tree_parent <= ram_q;
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > timeout_limit)
		begin
			$display("timeout: no result after %0d cycles", cycle_cnt);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_cnt++;
		if (got !== exp)
		begin
			$display("Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tree shapes and reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic build_tree(input int shape, input int n);
		logic [`HL_NODE_W-1:0] nodes [$];
		logic [`HL_NODE_W-1:0] a;
		logic [`HL_NODE_W-1:0] b;
		logic [`HL_NODE_W-1:0] inner;
		int                    pick;
		for (int i = 0; i < NODES; i++)
			tree_mem[i] = '0;
		inner = `HL_SYM_NUM;
		for (int k = 0; k < n; k++)
			nodes.push_back(k[`HL_NODE_W-1:0]);
		while (nodes.size() > 1)
		begin
			if (shape == 2)
			begin
				pick = $unsigned($random(seed)) % nodes.size();
				a = nodes[pick];
				nodes.delete(pick);
				pick = $unsigned($random(seed)) % nodes.size();
				b = nodes[pick];
				nodes.delete(pick);
			end
			else
			begin
				a = nodes.pop_front();
				b = nodes.pop_front();
			end
			tree_mem[a] = inner;
			tree_mem[b] = inner;
			// chain keeps extending the newest subtree
			if (shape == 1)
				nodes.push_front(inner);
			else
				nodes.push_back(inner);
			inner = inner + 1'b1;
		end
	endtask

	task automatic compute_model();
		logic [`HL_NODE_W-1:0] node;
		int                    depth;
		int                    overflow;
		int                    bits;
		overflow = 0;
		for (int i = 0; i <= `HL_MAX_BITS; i++)
			model_cnt[i] = 0;
		for (int leaf = 0; leaf < `HL_SYM_NUM; leaf++)
		begin
			node = leaf[`HL_NODE_W-1:0];
			depth = 0;
			while (tree_mem[node] != '0)
			begin
				node = tree_mem[node];
				depth++;
			end
			if (depth > `HL_MAX_BITS)
			begin
				model_cnt[`HL_MAX_BITS]++;
				overflow++;
			end
			else if (depth > 0)
				model_cnt[depth]++;
		end
		// RFC 1951 histogram repair
		while (overflow > 0)
		begin
			bits = `HL_MAX_BITS - 1;
			while (bits > 0 && model_cnt[bits] == 0)
				bits--;
			if (bits == 0)
				overflow = 0;
			else
			begin
				model_cnt[bits]--;
				model_cnt[bits + 1] += 2;
				model_cnt[`HL_MAX_BITS]--;
				overflow -= 2;
			end
		end
	endtask

	task automatic run_test(input int t);
		int shape;
		int leaves;
		int exp_total;
		int exp_max;
		int total;
		int longest;
		int errs_before;
		shape = 32'(test_words[4*t]);
		leaves = 32'(test_words[4*t+1]);
		exp_total = 32'(test_words[4*t+2]);
		exp_max = 32'(test_words[4*t+3]);
		errs_before = err_cnt;
		if (shape > 2 || leaves > `HL_SYM_NUM)
		begin
			$display("test %0d: bad shape code or leaf count in the input file", t + 1);
			err_cnt++;
			tests_failed++;
			return;
		end
		build_tree(shape, leaves);
		compute_model();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// old result is gone one cycle after the start
		check_value("done", 32'(done), 0);
		while (!done)
			@(negedge clk);
		total = 0;
		longest = 0;
		for (int i = 0; i <= `HL_MAX_BITS; i++)
		begin
			rd_addr = i[`HL_LEN_W-1:0];
			@(negedge clk);
			check_value($sformatf("rd_count[%0d]", i), 32'(rd_count), model_cnt[i]);
			total += 32'(rd_count);
			if (rd_count != '0)
				longest = i;
		end
		check_value("count sum", total, exp_total);
		if (exp_max != 0)
			check_value("longest length", longest, exp_max);
		if (err_cnt != errs_before)
			tests_failed++;
		$display("test %0d: shape %0d, %0d leaves, %0d errors", t + 1, shape, leaves,
			err_cnt - errs_before);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int n_tests;
		n_tests = 0;
		start = 1'b0;
		rstN = 1'b0;
		rd_addr = '0;
		for (int i = 0; i < 4*MAX_TESTS; i++)
			test_words[i] = END_MARK;
		$readmemh("verif/huff_len_input.txt", test_words);
		while (n_tests < MAX_TESTS && test_words[4*n_tests] != END_MARK)
		begin
			timeout_limit += 32'(test_words[4*n_tests+1]) * (32'(test_words[4*n_tests+1]) + 3);
			n_tests++;
		end
		timeout_limit += 200;
		repeat (4)
		begin
			@(negedge clk);
			check_value("done", 32'(done), 0);
			check_value("tree_rd", 32'(tree_rd), 0);
		end
		rstN = 1'b1;
		@(negedge clk);
		check_value("done", 32'(done), 0);
		check_value("tree_rd", 32'(tree_rd), 0);
		if (n_tests == 0)
		begin
			$display("no tests found in verif/huff_len_input.txt");
			err_cnt++;
		end
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors", n_tests,
			tests_failed, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/huff_len_assert.sv */
`timescale 1ns/100ps
`default_nettype none
`include "huff_len_macros.svh"

module huff_len_assert
(
	input logic                       clk,
	input logic                       rstN,
	input logic                       start,
	input logic                       done,
	input logic                       tree_rd,
	input huff_len_pkg::limit_state_t lim_state,
	input logic [`HL_CNT_W-1:0]       overflow
);

	import huff_len_pkg::*;

	logic repairing;

	assign repairing = (lim_state == LIM_SCAN) || (lim_state == LIM_ADJUST);

	// a start taken in DONE drops done on the next edge
	restart_clears_done: assert property (@(posedge clk) disable iff (!rstN)
		(start && done) |=> !done)
		else $error("done did not fall after a restart");

	no_read_when_done: assert property (@(posedge clk) disable iff (!rstN)
		!(tree_rd && done))
		else $error("tree RAM read while done is high");

	// the repair loop only lowers the overflow count
	overflow_never_rises: assert property (@(posedge clk) disable iff (!rstN)
		repairing |=> (overflow <= $past(overflow)))
		else $error("overflow rose during the repair loop");

endmodule

bind huff_len_top huff_len_assert u_assert
(
	.clk       (clk),
	.rstN      (rstN),
	.start     (start),
	.done      (done),
	.tree_rd   (tree_rd),
	.lim_state (u_limiter.state),
	.overflow  (u_limiter.overflow)
);

`default_nettype wire

/* verilog/huff_len_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "huff_len_macros.svh"

module huff_len_top
(
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   start,
	output logic                   done,
	output logic                   tree_rd,
	output logic [`HL_NODE_W-1:0]  tree_addr,
	input  logic [`HL_NODE_W-1:0]  tree_parent,
	input  logic [`HL_LEN_W-1:0]   rd_addr,
	output logic [`HL_CNT_W-1:0]   rd_count
);

	import huff_len_pkg::*;

	// tracer results
	logic                  len_valid;
	logic [`HL_LEN_W-1:0]  len_idx;
	logic                  len_over;
	logic                  trace_done;

	// limiter to counters
	adjust_op_t            adj_op;
	logic [`HL_LEN_W-1:0]  adj_idx;
	logic [`HL_LEN_W-1:0]  scan_idx;
	logic [`HL_CNT_W-1:0]  scan_count;

	tree_tracer u_tracer
	(
		.clk         (clk),
		.rstN        (rstN),
		.start       (start),
		.tree_rd     (tree_rd),
		.tree_addr   (tree_addr),
		.tree_parent (tree_parent),
		.len_valid   (len_valid),
		.len_idx     (len_idx),
		.len_over    (len_over),
		.trace_done  (trace_done)
	);

	bl_count_array u_count
	(
		.clk        (clk),
		.rstN       (rstN),
		.start      (start),
		.len_valid  (len_valid),
		.len_idx    (len_idx),
		.adj_op     (adj_op),
		.adj_idx    (adj_idx),
		.scan_idx   (scan_idx),
		.rd_addr    (rd_addr),
		.scan_count (scan_count),
		.rd_count   (rd_count)
	);

	length_limiter u_limiter
	(
		.clk        (clk),
		.rstN       (rstN),
		.start      (start),
		.trace_done (trace_done),
		.len_valid  (len_valid),
		.len_over   (len_over),
		.scan_count (scan_count),
		.adj_op     (adj_op),
		.adj_idx    (adj_idx),
		.scan_idx   (scan_idx),
		.done       (done)
	);

endmodule

`default_nettype wire

/* verilog/length_limiter.sv */
`timescale 1ns/100ps
`default_nettype none
`include "huff_len_macros.svh"

module length_limiter
(
	input  logic                     clk,
	input  logic                     rstN,
	input  logic                     start,
	input  logic                     trace_done,
	input  logic                     len_valid,
	input  logic                     len_over,
	input  logic [`HL_CNT_W-1:0]     scan_count,
	output huff_len_pkg::adjust_op_t adj_op,
	output logic [`HL_LEN_W-1:0]     adj_idx,
	output logic [`HL_LEN_W-1:0]     scan_idx,
	output logic                     done
);

	import huff_len_pkg::*;

	localparam logic [`HL_LEN_W-1:0] SCAN_TOP = `HL_MAX_BITS - 1;
	localparam logic [`HL_LEN_W-1:0] SCAN_LOW = 1;
	localparam logic [`HL_CNT_W-1:0] OVF_ONE  = 1;
	localparam logic [`HL_CNT_W-1:0] OVF_TWO  = 2;

	limit_state_t          state;
	// leaves whose true depth went past the limit
	logic [`HL_CNT_W-1:0]  overflow;
	logic [`HL_CNT_W-1:0]  overflow_dec;

	// each repair step settles two overflowed leaves
	assign overflow_dec = (overflow > OVF_TWO) ? overflow - OVF_TWO : '0;

	////////////////////////////////////////////////////////////////////////////
	// overflow count and repair loop
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state    <= LIM_IDLE;
			overflow <= '0;
			scan_idx <= SCAN_TOP;
		end
		else
		begin
			case (state)
				LIM_IDLE, LIM_DONE:
				begin
					if (start)
					begin
						state    <= LIM_TRACING;
						overflow <= '0;
					end
				end
				LIM_TRACING:
				begin
					if (len_valid && len_over)
						overflow <= overflow + OVF_ONE;
					if (trace_done)
					begin
						scan_idx <= SCAN_TOP;
						state    <= (overflow != '0) ? LIM_SCAN : LIM_DONE;
					end
				end
				LIM_SCAN:
				begin
					// look for the longest length below the limit still in use
					if (scan_count != '0)
						state <= LIM_ADJUST;
					else if (scan_idx == SCAN_LOW)
						state <= LIM_DONE;
					else
						scan_idx <= scan_idx - 1'b1;
				end
				LIM_ADJUST:
				begin
					overflow <= overflow_dec;
					scan_idx <= SCAN_TOP;
					state    <= (overflow_dec != '0) ? LIM_SCAN : LIM_DONE;
				end
				default:
				begin
					state <= LIM_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// outputs
	////////////////////////////////////////////////////////////////////////////

	// split is applied in the counter array on the ADJUST cycle
	assign adj_op  = (state == LIM_ADJUST) ? ADJ_SPLIT : ADJ_NONE;
	assign adj_idx = scan_idx;

	// readout is valid while done is high
	assign done = (state == LIM_DONE);

endmodule

`default_nettype wire

/* verilog/bl_count_array.sv */
`timescale 1ns/100ps
`default_nettype none
`include "huff_len_macros.svh"

module bl_count_array
(
	input  logic                     clk,
	input  logic                     rstN,
	input  logic                     start,
	input  logic                     len_valid,
	input  logic [`HL_LEN_W-1:0]     len_idx,
	input  huff_len_pkg::adjust_op_t adj_op,
	input  logic [`HL_LEN_W-1:0]     adj_idx,
	input  logic [`HL_LEN_W-1:0]     scan_idx,
	input  logic [`HL_LEN_W-1:0]     rd_addr,
	output logic [`HL_CNT_W-1:0]     scan_count,
	output logic [`HL_CNT_W-1:0]     rd_count
);

	import huff_len_pkg::*;

	localparam logic [`HL_LEN_W-1:0] LEN_MAX = `HL_MAX_BITS;
	localparam logic [`HL_CNT_W-1:0] CNT_ONE = 1;
	localparam logic [`HL_CNT_W-1:0] CNT_TWO = 2;

	// bl_count[1..15], entry 0 stays zero
	logic [`HL_CNT_W-1:0]  cnt [0:`HL_MAX_BITS];
	logic [`HL_LEN_W-1:0]  adj_nxt;

	assign adj_nxt = adj_idx + 1'b1;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i <= `HL_MAX_BITS; i++)
				cnt[i] <= '0;
		end
		else if (start)
		begin
			for (int i = 0; i <= `HL_MAX_BITS; i++)
				cnt[i] <= '0;
		end
		else if (len_valid)
		begin
			cnt[len_idx] <= cnt[len_idx] + CNT_ONE;
		end
		else if (adj_op == ADJ_INCR)
		begin
			cnt[adj_idx] <= cnt[adj_idx] + CNT_ONE;
		end
		else if (adj_op == ADJ_SPLIT)
		begin
			// one leaf moves down a level, taking a leaf from the longest length as sibling
			cnt[adj_idx] <= cnt[adj_idx] - CNT_ONE;
			if (adj_nxt == LEN_MAX)
			begin
				cnt[LEN_MAX] <= cnt[LEN_MAX] + CNT_ONE;
			end
			else
			begin
				cnt[adj_nxt] <= cnt[adj_nxt] + CNT_TWO;
				cnt[LEN_MAX] <= cnt[LEN_MAX] - CNT_ONE;
			end
		end
	end

	// scan port for the limiter
	assign scan_count = cnt[scan_idx];

	always_ff @(posedge clk)
	begin
		rd_count <= cnt[rd_addr];
	end

endmodule

`default_nettype wire

/* verilog/tree_tracer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "huff_len_macros.svh"

module tree_tracer
(
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   start,
	output logic                   tree_rd,
	output logic [`HL_NODE_W-1:0]  tree_addr,
	input  logic [`HL_NODE_W-1:0]  tree_parent,
	output logic                   len_valid,
	output logic [`HL_LEN_W-1:0]   len_idx,
	output logic                   len_over,
	output logic                   trace_done
);

	import huff_len_pkg::*;

	localparam logic [`HL_NODE_W-1:0] LAST_LEAF = `HL_SYM_NUM - 1;
	localparam logic [4:0]            DEPTH_MAX = `HL_MAX_BITS;
	localparam logic [4:0]            DEPTH_SAT = `HL_MAX_BITS + 1;

	trace_state_t             state;
	trace_state_t             state_nxt;
	logic [`HL_NODE_W-1:0]    leaf_cnt;
	// depth so far, stops counting at 16
	logic [4:0]               depth;
	logic                     parent_zero;
	logic                     last_leaf;

	assign parent_zero = (tree_parent == '0);
	assign last_leaf   = (leaf_cnt == LAST_LEAF);

	////////////////////////////////////////////////////////////////////////////
	// tree RAM access and length report
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		tree_rd   = 1'b0;
		tree_addr = leaf_cnt;
		case (state)
			TR_READ_LEAF, TR_NEXT_LEAF:
			begin
				tree_rd = 1'b1;
			end
			TR_WALK:
			begin
				// follow the parent unless the root was reached
				tree_rd   = !parent_zero;
				tree_addr = tree_parent;
			end
			default:
			begin
				tree_rd = 1'b0;
			end
		endcase
	end

	// depth 0 at the end of a walk means the leaf itself had no parent
	assign len_valid  = (state == TR_WALK) && parent_zero && (depth != '0);
	assign len_over   = len_valid && (depth > DEPTH_MAX);
	assign len_idx    = (depth > DEPTH_MAX) ? DEPTH_MAX[`HL_LEN_W-1:0] : depth[`HL_LEN_W-1:0];
	assign trace_done = (state == TR_DONE);

	////////////////////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			TR_IDLE:
			begin
				if (start)
					state_nxt = TR_READ_LEAF;
			end
			TR_READ_LEAF, TR_NEXT_LEAF:
			begin
				state_nxt = TR_WALK;
			end
			TR_WALK:
			begin
				if (parent_zero)
					state_nxt = last_leaf ? TR_DONE : TR_NEXT_LEAF;
			end
			default:
			begin
				state_nxt = TR_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state    <= TR_IDLE;
			leaf_cnt <= '0;
			depth    <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (state == TR_IDLE && start)
			begin
				leaf_cnt <= '0;
				depth    <= '0;
			end
			else if (state == TR_WALK)
			begin
				if (parent_zero)
				begin
					// next leaf starts from depth 0
					depth <= '0;
					if (!last_leaf)
						leaf_cnt <= leaf_cnt + 1'b1;
				end
				else if (depth != DEPTH_SAT)
				begin
					depth <= depth + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/huff_len_pkg.sv */
`default_nettype none

package huff_len_pkg;

	// tree tracer FSM
	typedef enum logic [2:0] {
		TR_IDLE,
		TR_READ_LEAF,
		TR_WALK,
		TR_NEXT_LEAF,
		TR_DONE
	} trace_state_t;

	// length limiter FSM
	typedef enum logic [2:0] {
		LIM_IDLE,
		LIM_TRACING,
		LIM_SCAN,
		LIM_ADJUST,
		LIM_DONE
	} limit_state_t;

	// update applied to the length counters by the limiter
	typedef enum logic [1:0] {
		ADJ_NONE,
		ADJ_INCR,
		ADJ_SPLIT
	} adjust_op_t;

endpackage

`default_nettype wire

/* verilog/huff_len_macros.svh */
`ifndef HUFF_LEN_MACROS_SVH
`define HUFF_LEN_MACROS_SVH

// tree node index, leaves 0..255 and inner nodes 256..511
`define HL_NODE_W	9

// leaves in one tree
`define HL_SYM_NUM	256

// index into the length counters
`define HL_LEN_W	4

// longest code allowed after limiting (RFC 1951)
`define HL_MAX_BITS	15

// width of one length count and of the overflow register
`define HL_CNT_W	9

`endif
